// File: common/lane_fmt_pkg.sv
/*
   lane format definitions for the packet regrouper
   input word and end-code layout, the stored word kept in the
   buffer, and the decode from end code to empty count and error
*/
package lane_fmt_pkg;

   // beat geometry
   localparam int word_width     = 64;
   localparam int bytes_per_word = 8;
   localparam int lanes_in       = 2;

   // 0..lanes_in words per beat
   localparam int count_width    = $clog2(lanes_in + 1);

   // end code: 0000 none, 1vvv end with vvv valid bytes (0 = 8)
   // 0001 end with error, anything else malformed
   localparam int eop_code_width = 4;
   localparam int empty_width    = 4;

   // start bit, end code, then data
   localparam int stored_word_width = word_width + eop_code_width + 1;

   typedef logic [word_width-1:0]     word_t;
   typedef logic [eop_code_width-1:0] eop_code_t;

   typedef struct packed {
      logic      sop;
      eop_code_t eop;
      word_t     data;
   } stored_word_t;

   typedef struct packed {
      logic                   error;
      logic [empty_width-1:0] empty;
   } end_fields_t;

   // any nonzero code closes the packet, malformed ones as error ends
   function automatic logic eop_is_end(eop_code_t code);
      return |code;
   endfunction

   // in_first set when the group ends in its first (upper) word
   function automatic end_fields_t eop_empty_of(eop_code_t code, logic in_first);
      end_fields_t            f;
      logic [empty_width-1:0] valid_bytes;
      f = '0;
      // zero in the byte field means a full word
      valid_bytes = (code[2:0] == 3'd0) ? empty_width'(bytes_per_word)
                                        : empty_width'(code[2:0]);
      if (code[eop_code_width-1]) begin
         f.empty = empty_width'(bytes_per_word) - valid_bytes;
         // lower word of the beat is empty too
         if (in_first) begin
            f.empty = f.empty + empty_width'(bytes_per_word);
         end
      end else if (code != '0) begin
         // 0001 and malformed codes, empty stays 0
         f.error = 1'b1;
      end
      return f;
   endfunction

endpackage

// File: common/regroup_cfg_pkg.sv
/*
   regrouper buffer configuration
   word buffer sizing and the holding count that flags overflow
*/
package regroup_cfg_pkg;

   // buffer address bits, one address per stored word
   localparam int addr_width = 6;

   // words held, the address wraps at this point
   localparam int buf_depth = 1 << addr_width;

   // holding above this means the writer may lap the reader
   localparam int overflow_level = buf_depth - 2;

   typedef logic [addr_width-1:0] addr_t;

endpackage

// File: regroup/regroup_writer.sv
/*
   regrouper producer
   packs each valid input word with its start bit and end code,
   flags packet ends for the boundary map and keeps the write address
*/
`timescale 1ns/10ps

module regroup_writer
   import lane_fmt_pkg::*, regroup_cfg_pkg::*;
(
   input  logic                          clk,
   input  logic                          arst,
   input  logic [count_width-1:0]        din_num_valid,
   input  logic [lanes_in-1:0]           din_sop,
   input  eop_code_t [lanes_in-1:0]      din_eopbits,
   input  word_t [lanes_in-1:0]          din,
   output addr_t                         wr_addr,
   output logic [count_width-1:0]        wr_count,
   output stored_word_t [lanes_in-1:0]   wr_words,
   output logic [lanes_in-1:0]           wr_boundary
);

   // per lane valid, upper lane is first in time
   logic [lanes_in-1:0] lane_valid;

   ////////////////////////////////////////////////////////////
   // word count
   ////////////////////////////////////////////////////////////

   // 3 is not a legal count, treat it as a full beat
   always_comb begin
      if (din_num_valid > count_width'(lanes_in)) begin
         wr_count = count_width'(lanes_in);
      end else begin
         wr_count = din_num_valid;
      end
   end

   ////////////////////////////////////////////////////////////
   // pack stored words
   ////////////////////////////////////////////////////////////

   // valid words sit at the top, upper slot goes to wr_addr
   always_comb begin
      for (int i = 0; i < lanes_in; i++) begin
         lane_valid[i] = wr_count >= count_width'(lanes_in - i);
         wr_words[i]   = '0;
         // idle lanes stay zero so nothing stray reaches the buffer
         if (lane_valid[i]) begin
            wr_words[i].sop  = din_sop[i];
            wr_words[i].eop  = din_eopbits[i];
            wr_words[i].data = din[i];
         end
         wr_boundary[i] = lane_valid[i] & eop_is_end(din_eopbits[i]);
      end
   end

   ////////////////////////////////////////////////////////////
   // write address
   ////////////////////////////////////////////////////////////

   // words land in the buffer on this same edge
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         wr_addr <= '0;
      end else begin
         wr_addr <= wr_addr + addr_t'(wr_count);
      end
   end

endmodule

// File: regroup/regroup_word_ram.sv
/*
   regrouper word buffer
   word-addressed storage, two words written and two read per cycle
   with wraparound, plus a packet boundary map read at the head
*/
`timescale 1ns/10ps

module regroup_word_ram
   import lane_fmt_pkg::*, regroup_cfg_pkg::*;
(
   input  logic                          clk,
   input  logic                          arst,
   input  addr_t                         wr_addr,
   input  logic [count_width-1:0]        wr_count,
   input  stored_word_t [lanes_in-1:0]   wr_words,
   input  logic [lanes_in-1:0]           wr_boundary,
   input  addr_t                         rd_addr,
   input  logic [count_width-1:0]        rd_count,
   output stored_word_t [lanes_in-1:0]   rd_words,
   output logic [lanes_in-1:0]           head_boundary
);

   // storage
   logic [stored_word_width-1:0] mem [buf_depth];

   // one bit per address, set where a packet ends
   logic [buf_depth-1:0] bnd_map;

   // second address of each port, wraps with the buffer
   addr_t wr_addr_nxt;
   addr_t rd_addr_nxt;

   assign wr_addr_nxt = wr_addr + addr_t'(1);
   assign rd_addr_nxt = rd_addr + addr_t'(1);

   ////////////////////////////////////////////////////////////
   // write port
   ////////////////////////////////////////////////////////////

   // upper slot first in time, at the lower address
   always_ff @(posedge clk) begin
      if (wr_count >= count_width'(1)) begin
         mem[wr_addr] <= wr_words[1];
      end
      if (wr_count >= count_width'(2)) begin
         mem[wr_addr_nxt] <= wr_words[0];
      end
   end

   ////////////////////////////////////////////////////////////
   // boundary map
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         bnd_map <= '0;
      end else begin
         // drop flags of words the reader takes this edge
         if (rd_count >= count_width'(1)) begin
            bnd_map[rd_addr] <= 1'b0;
         end
         if (rd_count >= count_width'(2)) begin
            bnd_map[rd_addr_nxt] <= 1'b0;
         end
         // new words win over a clear of the same slot
         if (wr_count >= count_width'(1)) begin
            bnd_map[wr_addr] <= wr_boundary[1];
         end
         if (wr_count >= count_width'(2)) begin
            bnd_map[wr_addr_nxt] <= wr_boundary[0];
         end
      end
   end

   // head word and the one after it, no clock
   assign head_boundary = {bnd_map[rd_addr], bnd_map[rd_addr_nxt]};

   ////////////////////////////////////////////////////////////
   // read port
   ////////////////////////////////////////////////////////////

   // two consecutive words every cycle, the reader picks what it needs
   always_ff @(posedge clk) begin
      rd_words[1] <= mem[rd_addr];
      rd_words[0] <= mem[rd_addr_nxt];
   end

endmodule

// File: regroup/regroup_reader.sv
/*
   regrouper consumer
   schedules one or two word group reads so every start lands in
   the upper word, tracks holding and overflow, formats the stream
*/
`timescale 1ns/10ps

module regroup_reader
   import lane_fmt_pkg::*, regroup_cfg_pkg::*;
(
   input  logic                              clk,
   input  logic                              arst,
   input  addr_t                             wr_addr,
   input  logic [lanes_in-1:0]               head_boundary,
   input  stored_word_t [lanes_in-1:0]       rd_words,
   output addr_t                             rd_addr,
   output logic [count_width-1:0]            rd_count,
   output logic [lanes_in*word_width-1:0]    avl_dout,
   output logic                              avl_sop,
   output logic                              avl_eop,
   output logic [empty_width-1:0]            avl_empty,
   output logic                              avl_valid,
   output logic                              avl_error,
   output logic                              overflow
);

   // words written but not yet scheduled
   addr_t                         holding;
   addr_t                         rd_addr_nxt;
   logic                          rd_end;

   // group count and end flag, lined up with rd_words
   logic [count_width-1:0]        cnt_d1;
   logic                          end_d1;

   // group stage in front of the output register
   stored_word_t [lanes_in-1:0]   grp_words;
   logic [count_width-1:0]        grp_count;
   logic                          grp_end;

   // output beat before its register
   stored_word_t                  end_word;
   end_fields_t                   end_fields;
   logic                          one_word;
   logic [lanes_in*word_width-1:0] beat_data;

   ////////////////////////////////////////////////////////////
   // read schedule
   ////////////////////////////////////////////////////////////

   // an end at the head closes a one word group
   always_comb begin
      if (head_boundary[1] && holding >= addr_t'(1)) begin
         rd_count = count_width'(1);
      end else if (holding >= addr_t'(2)) begin
         rd_count = count_width'(2);
      end else begin
         rd_count = '0;
      end
      rd_end = (rd_count == count_width'(1)) ? head_boundary[1] : head_boundary[0];
   end

   assign rd_addr_nxt = rd_addr + addr_t'(rd_count);

   // holding counts against the advanced read address so a group
   // is never scheduled twice
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         rd_addr  <= '0;
         holding  <= '0;
         cnt_d1   <= '0;
         end_d1   <= 1'b0;
         overflow <= 1'b0;
      end else begin
         rd_addr <= rd_addr_nxt;
         holding <= wr_addr - rd_addr_nxt;
         cnt_d1  <= rd_count;
         end_d1  <= rd_end & (rd_count != '0);
         // sticky until reset
         if (holding > addr_t'(overflow_level)) begin
            overflow <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // group stage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      grp_words <= rd_words;
   end

   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         grp_count <= '0;
         grp_end   <= 1'b0;
      end else begin
         grp_count <= cnt_d1;
         grp_end   <= end_d1;
      end
   end

   ////////////////////////////////////////////////////////////
   // output beat
   ////////////////////////////////////////////////////////////

   // end code comes from the last word of the group
   always_comb begin
      one_word   = grp_count == count_width'(1);
      end_word   = one_word ? grp_words[1] : grp_words[0];
      end_fields = eop_empty_of(end_word.eop, one_word);
      // single word goes high, low half zero
      if (one_word) begin
         beat_data = {grp_words[1].data, word_t'(0)};
      end else begin
         beat_data = {grp_words[1].data, grp_words[0].data};
      end
   end

   // everything zero between beats
   always_ff @(posedge clk or posedge arst) begin
      if (arst) begin
         avl_dout  <= '0;
         avl_sop   <= 1'b0;
         avl_eop   <= 1'b0;
         avl_empty <= '0;
         avl_valid <= 1'b0;
         avl_error <= 1'b0;
      end else if (grp_count != '0) begin
         avl_dout  <= beat_data;
         avl_sop   <= grp_words[1].sop;
         avl_eop   <= grp_end;
         avl_empty <= grp_end ? end_fields.empty : '0;
         avl_valid <= 1'b1;
         avl_error <= grp_end & end_fields.error;
      end else begin
         avl_dout  <= '0;
         avl_sop   <= 1'b0;
         avl_eop   <= 1'b0;
         avl_empty <= '0;
         avl_valid <= 1'b0;
         avl_error <= 1'b0;
      end
   end

endmodule

// File: design/regroup_top.sv
/*
   packet regrouper top level
   producer, word buffer and consumer on one clock, so each
   packet start leaves in the upper word of an output beat
*/
`timescale 1ns/10ps

module regroup_top
   import lane_fmt_pkg::*, regroup_cfg_pkg::*;
(
   input  logic                              clk,
   input  logic                              arst,
   input  logic [count_width-1:0]            din_num_valid,
   input  logic [lanes_in-1:0]               din_sop,
   input  eop_code_t [lanes_in-1:0]          din_eopbits,
   input  word_t [lanes_in-1:0]              din,
   output logic [lanes_in*word_width-1:0]    avl_dout,
   output logic                              avl_sop,
   output logic                              avl_eop,
   output logic [empty_width-1:0]            avl_empty,
   output logic                              avl_valid,
   output logic                              avl_error,
   output logic                              overflow
);

   // write side
   addr_t                        wr_addr;
   logic [count_width-1:0]       wr_count;
   stored_word_t [lanes_in-1:0]  wr_words;
   logic [lanes_in-1:0]          wr_boundary;

   // read side
   addr_t                        rd_addr;
   logic [count_width-1:0]       rd_count;
   stored_word_t [lanes_in-1:0]  rd_words;
   logic [lanes_in-1:0]          head_boundary;

   regroup_writer writer_i (
      .clk           (clk),
      .arst          (arst),
      .din_num_valid (din_num_valid),
      .din_sop       (din_sop),
      .din_eopbits   (din_eopbits),
      .din           (din),
      .wr_addr       (wr_addr),
      .wr_count      (wr_count),
      .wr_words      (wr_words),
      .wr_boundary   (wr_boundary)
   );

   regroup_word_ram ram_i (
      .clk           (clk),
      .arst          (arst),
      .wr_addr       (wr_addr),
      .wr_count      (wr_count),
      .wr_words      (wr_words),
      .wr_boundary   (wr_boundary),
      .rd_addr       (rd_addr),
      .rd_count      (rd_count),
      .rd_words      (rd_words),
      .head_boundary (head_boundary)
   );

   regroup_reader reader_i (
      .clk           (clk),
      .arst          (arst),
      .wr_addr       (wr_addr),
      .head_boundary (head_boundary),
      .rd_words      (rd_words),
      .rd_addr       (rd_addr),
      .rd_count      (rd_count),
      .avl_dout      (avl_dout),
      .avl_sop       (avl_sop),
      .avl_eop       (avl_eop),
      .avl_empty     (avl_empty),
      .avl_valid     (avl_valid),
      .avl_error     (avl_error),
      .overflow      (overflow)
   );

endmodule

// File: verification/regroup_model.svh
/*
   regrouper reference model for the testbench
   LCG random source, striping of packets into input words and the
   expected output beats under the start alignment rule
*/
`ifndef regroup_model_svh
`define regroup_model_svh

// one expected output beat
typedef struct packed {
   logic [2*word_width-1:0] dout;
   logic                    sop;
   logic                    eop;
   logic [empty_width-1:0]  empty;
   logic                    error;
} beat_t;

// words still to be driven, first in time at the front
stored_word_t word_q [$];
// beats the DUT owes, oldest first
beat_t        exp_q [$];

logic [31:0] lcg_state = 32'd15570;

// upper 16 bits of the next LCG state
function automatic int next_random();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return int'(lcg_state[31:16]);
endfunction

function automatic word_t random_word();
   word_t w;
   w = '0;
   for (int i = 0; i < 4; i++) begin
      w = {w[47:0], 16'(next_random())};
   end
   return w;
endfunction

// end_kind 0 normal end, 1 error code, 2 malformed code
function automatic void add_packet(input int len, input int end_kind);
   int           n_words;
   int           last_bytes;
   eop_code_t    code;
   stored_word_t w [$];
   stored_word_t one;
   beat_t        b;
   n_words    = (len + 7) / 8;
   last_bytes = len - 8 * (n_words - 1);
   case (end_kind)
      // byte count 8 wraps to 000
      0:       code = {1'b1, 3'(last_bytes)};
      1:       code = 4'b0001;
      default: code = 4'(2 + next_random() % 6);
   endcase
   for (int i = 0; i < n_words; i++) begin
      one.sop  = (i == 0);
      one.eop  = (i == n_words - 1) ? code : 4'b0000;
      one.data = random_word();
      w.push_back(one);
   end
   // pairs from the packet start, an odd last word goes alone
   for (int i = 0; i < n_words; i += 2) begin
      b     = '0;
      b.sop = (i == 0);
      b.eop = (i + 2 >= n_words);
      if (i + 1 < n_words) begin
         b.dout = {w[i].data, w[i+1].data};
      end else begin
         b.dout = {w[i].data, word_t'(0)};
      end
      // beat holds 16 bytes, empty is what the packet leaves unused
      if (b.eop && end_kind != 0) begin
         b.error = 1'b1;
      end else if (b.eop && i + 1 < n_words) begin
         b.empty = 4'(16 - (8 + last_bytes));
      end else if (b.eop) begin
         b.empty = 4'(16 - last_bytes);
      end
      exp_q.push_back(b);
   end
   foreach (w[i]) begin
      word_q.push_back(w[i]);
   end
endfunction

`endif

// File: verification/regroup_tb.sv
/*
   testbench for the packet regrouper
   random packets through the DUT against a regrouping model,
   plus idle, end code, single word and overflow tests
*/
`timescale 1ns/10ps

module regroup_tb
   import lane_fmt_pkg::*, regroup_cfg_pkg::*;
();

   localparam int clk_period   = 4;
   localparam int reset_cycles = 8;
   localparam int idle_cycles  = 20;
   // packets per test
   localparam int n_random     = 60;
   localparam int n_sweep      = 32;
   localparam int n_errend     = 30;
   localparam int n_single     = 40;
   localparam int flood_cycles = 2 * buf_depth;
   // at most 8 words a packet, 4 cycles a word leaves room for gaps
   localparam int stim_cycles  = reset_cycles + idle_cycles + flood_cycles + 40
                                 + 4 * 8 * (n_random + n_sweep + n_errend + n_single);
   localparam int watchdog_cycles = stim_cycles + 6 * buf_depth;

   logic                           clk;
   logic                           arst;
   logic [count_width-1:0]         din_num_valid;
   logic [lanes_in-1:0]            din_sop;
   eop_code_t [lanes_in-1:0]       din_eopbits;
   word_t [lanes_in-1:0]           din;
   logic [lanes_in*word_width-1:0] avl_dout;
   logic                           avl_sop;
   logic                           avl_eop;
   logic [empty_width-1:0]         avl_empty;
   logic                           avl_valid;
   logic                           avl_error;
   logic                           overflow;

   int errors      = 0;
   int checks      = 0;
   int err_mark    = 0;
   bit check_beats = 1'b0;

   `include "regroup_model.svh"

   regroup_top dut_i (
      .clk           (clk),
      .arst          (arst),
      .din_num_valid (din_num_valid),
      .din_sop       (din_sop),
      .din_eopbits   (din_eopbits),
      .din           (din),
      .avl_dout      (avl_dout),
      .avl_sop       (avl_sop),
      .avl_eop       (avl_eop),
      .avl_empty     (avl_empty),
      .avl_valid     (avl_valid),
      .avl_error     (avl_error),
      .overflow      (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("watchdog expired after %0d cycles, the run never finished", watchdog_cycles);
      $display("TEST FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   task automatic check_field(input string name, input logic [127:0] got,
                              input logic [127:0] expected);
      checks++;
      assert (got === expected) else begin
         $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, got);
         errors++;
      end
   endtask

   // outputs settled in the last cycle, compared in order with the model
   always @(posedge clk) begin : beat_check
      beat_t exp_beat;
      if (check_beats && avl_valid) begin
         assert (exp_q.size() > 0) else begin
            $display("output beat at %0t while the model expects none", $time);
            errors++;
         end
         if (exp_q.size() > 0) begin
            exp_beat = exp_q.pop_front();
            check_field("avl_dout", avl_dout, exp_beat.dout);
            check_field("avl_sop", 128'(avl_sop), 128'(exp_beat.sop));
            check_field("avl_eop", 128'(avl_eop), 128'(exp_beat.eop));
            check_field("avl_empty", 128'(avl_empty), 128'(exp_beat.empty));
            check_field("avl_error", 128'(avl_error), 128'(exp_beat.error));
         end
      end else if (check_beats) begin
         // no beat, all fields zero
         check_field("avl_dout", avl_dout, '0);
         check_field("avl_empty", 128'(avl_empty), '0);
         check_field("avl_sop,avl_eop,avl_error", 128'({avl_sop, avl_eop, avl_error}), '0);
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   // 0.75 words per cycle on average
   function automatic int pick_count();
      int r;
      r = next_random() % 8;
      if (r < 3) return 0;
      if (r < 7) return 1;
      return 2;
   endfunction

   // first word in time goes to the upper lane
   task automatic drive_words(input bit full_rate);
      int           n;
      stored_word_t a;
      stored_word_t b;
      while (word_q.size() > 0) begin
         @(posedge clk);
         n = full_rate ? 2 : pick_count();
         if (n > word_q.size()) n = word_q.size();
         a = '0;
         b = '0;
         if (n >= 1) a = word_q.pop_front();
         if (n == 2) b = word_q.pop_front();
         din_num_valid <= count_width'(n);
         din_sop       <= {a.sop, b.sop};
         din_eopbits   <= {a.eop, b.eop};
         din           <= {a.data, b.data};
      end
      @(posedge clk);
      din_num_valid <= '0;
      din_sop       <= '0;
      din_eopbits   <= '0;
      din           <= '0;
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, errors - err_mark);
      err_mark = errors;
   endtask

   // wait for the model queue to empty, then a few quiet cycles
   task automatic finish_test(input int num, input string name);
      int waited;
      waited = 0;
      while (exp_q.size() > 0 && waited < buf_depth / 2) begin
         @(posedge clk);
         waited++;
      end
      assert (exp_q.size() == 0) else begin
         $display("test %0d: traffic ended with %0d expected beats missing", num, exp_q.size());
         errors++;
         exp_q.delete();
      end
      repeat (8) @(posedge clk);
      check_field("overflow", 128'(overflow), '0);
      report_test(num, name);
   endtask

   initial begin
      arst          <= 1'b1;
      din_num_valid <= '0;
      din_sop       <= '0;
      din_eopbits   <= '0;
      din           <= '0;
      repeat (reset_cycles) @(posedge clk);
      arst <= 1'b0;
      check_beats = 1'b1;

      // idle after reset
      repeat (idle_cycles) begin
         @(posedge clk);
         check_field("avl_valid", 128'(avl_valid), '0);
         check_field("overflow", 128'(overflow), '0);
      end
      report_test(1, "idle after reset");

      repeat (n_random) add_packet(1 + next_random() % 64, 0);
      drive_words(1'b0);
      finish_test(2, "random packets");

      // every length modulo a beat, twice
      for (int k = 0; k < n_sweep; k++) begin
         add_packet(1 + k % 16 + 16 * (next_random() % 4), 0);
      end
      drive_words(1'b0);
      finish_test(3, "empty count sweep");

      repeat (n_errend) add_packet(1 + next_random() % 64, next_random() % 3);
      drive_words(1'b0);
      finish_test(4, "error and malformed ends");

      repeat (n_single) add_packet(1 + next_random() % 8, 0);
      drive_words(1'b0);
      finish_test(5, "single word packets");

      // flood at two words a cycle, data not checked
      check_beats = 1'b0;
      repeat (2 * flood_cycles) add_packet(1 + next_random() % 8, 0);
      exp_q.delete();
      drive_words(1'b1);
      repeat (20) begin
         check_field("overflow", 128'(overflow), 128'(1));
         @(posedge clk);
      end
      arst <= 1'b1;
      repeat (reset_cycles) @(posedge clk);
      arst <= 1'b0;
      @(posedge clk);
      check_field("overflow", 128'(overflow), '0);
      report_test(6, "overflow flag");

      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: regroup_top.f
+incdir+verification
common/lane_fmt_pkg.sv
common/regroup_cfg_pkg.sv
regroup/regroup_writer.sv
regroup/regroup_word_ram.sv
regroup/regroup_reader.sv
design/regroup_top.sv
verification/regroup_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the regrouper testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -j 0 \
   --top-module regroup_tb --Mdir "$build_dir" -f regroup_top.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$("./$build_dir/Vregroup_tb")
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "TEST PASSED" <<< "$sim_out"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
